/* all.f */
hw/cas_pkg.sv
hw/tape_fetch.sv
hw/byte_fifo.sv
hw/fsk_modulator.sv
hw/cas_player.sv
test/tape_mem_model.sv
test/cas_player_sva.sv
test/tb_cas_player.sv

/* Makefile */
# Verilator build and regression run for the cassette image player

VERILATOR ?= verilator
TOP       ?= tb_cas_player
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_TEXT ?= Regression failed
PASS_TEXT ?= Regression passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit code does not
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Failure found in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_cas_player.sv */
// Testbench top that runs directed tests on cas_player and decodes its FSK tape output
`default_nettype none

module tb_cas_player;
   import cas_pkg::*;

   localparam int half_period = 4;
   localparam int frame_clks  = 4 * half_period * FRAME_BITS;
   // Six tests of up to 8 frames plus idle watches stay well below this
   localparam int max_cycles  = 20000;

   logic        clk21m;
   logic        rst_n;
   logic        cas_download;
   logic        rewind_req;
   logic        motor_n;
   tape_addr_t  tape_len;
   mem_req_t    mem_req;
   mem_rsp_t    mem_rsp;
   logic        cas_out;
   int unsigned max_latency;

   tape_byte_t            image_exp [256];
   tape_byte_t            decoded [$];
   logic                  dec_clear;
   logic                  prev_out;
   logic                  in_frame;
   logic                  bit_val;
   logic [FRAME_BITS-1:0] frame_bits;
   int                    since;
   int                    bit_idx;
   int                    units;
   int                    cycles = 0;
   int                    errors = 0;

   cas_player #(
      .half_period (half_period)
   ) cas_player_inst (
      .clk21m       (clk21m),
      .rst_n        (rst_n),
      .cas_download (cas_download),
      .rewind_req   (rewind_req),
      .motor_n      (motor_n),
      .tape_len     (tape_len),
      .mem_rsp      (mem_rsp),
      .mem_req      (mem_req),
      .cas_out      (cas_out)
   );

   tape_mem_model mem_model_inst (
      .clk21m      (clk21m),
      .rst_n       (rst_n),
      .max_latency (max_latency),
      .mem_req     (mem_req),
      .mem_rsp     (mem_rsp)
   );

   initial begin
      clk21m = 1'b0;
      forever #4 clk21m = ~clk21m;
   end

   // ============================================================
   // Failure reporting
   // ============================================================

   task automatic abort_run(input string msg);
      errors++;
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("FAILED t=%0t %s got 0x%0h expected 0x%0h",
                             $time, name, got, exp));
      end
   endtask

   always @(posedge clk21m) begin
      cycles++;
      if (cycles >= max_cycles) begin
         abort_run($sformatf("Run did not finish within %0d cycles", max_cycles));
      end
      if (rst_n && mem_req.rd && (mem_req.addr >= tape_len)) begin
         abort_run($sformatf("Read issued at address %0d, tape holds only %0d bytes",
                             mem_req.addr, tape_len));
      end
   end

   // ============================================================
   // FSK decoder
   // ============================================================

   task automatic finish_frame();
      check_eq("start bit", frame_bits[0], 1'b0);
      check_eq("stop bit 1", frame_bits[9], 1'b1);
      decoded.push_back(frame_bits[8:1]);
      in_frame = 1'b0;
   endtask

   // One half-cycle of d clocks has just ended
   task automatic take_half(input int d);
      logic is_short;
      is_short = 1'b0;
      if (d == half_period) begin
         is_short = 1'b1;
      end else if (d != 2 * half_period) begin
         abort_run($sformatf("Half-cycle of %0d clocks inside a frame at bit %0d", d, bit_idx));
      end
      if (units == 0) begin
         bit_val = is_short;
         if (bit_idx == FRAME_BITS - 1) begin
            check_eq("stop bit 2", is_short, 1'b1);
         end
      end else if (is_short != bit_val) begin
         abort_run($sformatf("Bit %0d mixes 1200 Hz and 2400 Hz half-cycles", bit_idx));
      end
      units = units + (is_short ? 1 : 2);
      if (units == 4) begin
         frame_bits[bit_idx] = bit_val;
         bit_idx++;
         units = 0;
      end else if ((bit_idx == FRAME_BITS - 1) && (units == 3)) begin
         // Last half of the frame has no closing toggle of its own
         frame_bits[bit_idx] = bit_val;
         finish_frame();
      end
   endtask

   always @(posedge clk21m) begin
      if (!rst_n || dec_clear) begin
         prev_out = cas_out;
         since    = 0;
         in_frame = 1'b0;
      end else begin
         since++;
         if (cas_out != prev_out) begin
            prev_out = cas_out;
            if (!in_frame) begin
               in_frame = 1'b1;
               bit_idx  = 0;
               units    = 0;
            end else begin
               take_half(since);
            end
            since = 0;
         end
      end
   end

   // ============================================================
   // Helpers
   // ============================================================

   task automatic load_tape(input int len, input int unsigned lat);
      tape_byte_t b;
      for (int i = 0; i < len; i++) begin
         b = tape_byte_t'($urandom);
         image_exp[i] = b;
         mem_model_inst.image[i] = b;
      end
      @(posedge clk21m);
      motor_n      <= 1'b1;
      tape_len     <= tape_addr_t'(len);
      max_latency  <= lat;
      dec_clear    <= 1'b1;
      cas_download <= 1'b1;
      repeat (3) @(posedge clk21m);
      cas_download <= 1'b0;
      repeat (2) @(posedge clk21m);
      dec_clear <= 1'b0;
      decoded.delete();
      @(negedge clk21m);
   endtask

   task automatic start_motor();
      @(posedge clk21m);
      motor_n <= 1'b0;
   endtask

   task automatic wait_bytes(input int n);
      while (decoded.size() < n) begin
         @(negedge clk21m);
      end
   endtask

   task automatic hold_quiet(input int n);
      logic level;
      level = cas_out;
      repeat (n) begin
         @(negedge clk21m);
         check_eq("cas_out", cas_out, level);
         check_eq("mem_req.rd", mem_req.rd, 1'b0);
      end
   endtask

   // Waits for every byte and then watches two more frame times
   task automatic finish_tape(input int len);
      wait_bytes(len);
      repeat (2 * frame_clks) @(negedge clk21m);
      check_eq("decoded count", decoded.size(), len);
      for (int i = 0; i < len; i++) begin
         check_eq($sformatf("decoded byte %0d", i), decoded[i], image_exp[i]);
      end
   endtask

   // ============================================================
   // Tests
   // ============================================================

   task automatic test_idle_before_load();
      // Nonzero length so only the missing load keeps the fetcher quiet
      @(posedge clk21m);
      tape_len <= tape_addr_t'(8);
      start_motor();
      @(negedge clk21m);
      check_eq("cas_out", cas_out, 1'b0);
      hold_quiet(50);
   endtask

   task automatic test_full_playback();
      load_tape(8, 2);
      start_motor();
      finish_tape(8);
   endtask

   task automatic test_motor_pause();
      logic level;
      int   clocks;
      load_tape(8, 2);
      start_motor();
      wait_bytes(2);
      // Stop in the middle of the third frame
      repeat (50) @(posedge clk21m);
      motor_n <= 1'b1;
      repeat (frame_clks + 50) @(negedge clk21m);
      hold_quiet(100);
      check_eq("decoded count", decoded.size(), 3);
      level = cas_out;
      start_motor();
      clocks = 0;
      while ((cas_out == level) && (clocks < 10)) begin
         @(negedge clk21m);
         clocks++;
      end
      if (clocks > 2) begin
         abort_run($sformatf("First toggle after motor restart took %0d clocks", clocks));
      end
      finish_tape(8);
   endtask

   task automatic test_rewind();
      logic prev_level;
      load_tape(8, 2);
      start_motor();
      wait_bytes(3);
      repeat (40) @(negedge clk21m);
      // Rewind lands just after a rising toggle, while the level is high
      prev_level = cas_out;
      @(negedge clk21m);
      while (prev_level || !cas_out) begin
         prev_level = cas_out;
         @(negedge clk21m);
      end
      @(posedge clk21m);
      dec_clear  <= 1'b1;
      rewind_req <= 1'b1;
      @(posedge clk21m);
      rewind_req <= 1'b0;
      @(negedge clk21m);
      check_eq("cas_out", cas_out, 1'b0);
      @(posedge clk21m);
      dec_clear <= 1'b0;
      decoded.delete();
      finish_tape(8);
   endtask

   task automatic test_end_of_tape();
      load_tape(5, 3);
      start_motor();
      wait_bytes(5);
      hold_quiet(300);
      finish_tape(5);
   endtask

   task automatic test_slow_memory();
      load_tape(8, 5);
      start_motor();
      finish_tape(8);
   endtask

   initial begin
      void'($urandom(32'h2582_898b));
      rst_n        <= 1'b0;
      cas_download <= 1'b0;
      rewind_req   <= 1'b0;
      motor_n      <= 1'b1;
      tape_len     <= '0;
      max_latency  <= 1;
      dec_clear    <= 1'b0;
      repeat (3) @(posedge clk21m);
      rst_n <= 1'b1;
      @(negedge clk21m);

      test_idle_before_load();
      test_full_playback();
      test_motor_pause();
      test_rewind();
      test_end_of_tape();
      test_slow_memory();

      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* test/cas_player_sva.sv */
// Handshake and idle-level assertions, bound into every cas_player instance
`default_nettype none

module cas_player_sva (
   input logic              clk21m,
   input logic              rst_n,
   input cas_pkg::mem_req_t mem_req,
   input cas_pkg::mem_rsp_t mem_rsp,
   input logic              loaded,
   input logic              cas_out
);

   // Request frozen until memory answers
   read_held: assert property (@(posedge clk21m) disable iff (!rst_n)
      (mem_req.rd && !mem_rsp.ready) |=> (mem_req.rd && $stable(mem_req.addr)))
      else $error("read request changed while waiting for ready");

   ready_with_rd: assert property (@(posedge clk21m) disable iff (!rst_n)
      mem_rsp.ready |-> mem_req.rd)
      else $error("ready seen without a pending read");

   // No tone before an image is present
   idle_low: assert property (@(posedge clk21m) disable iff (!rst_n)
      !loaded |-> !cas_out)
      else $error("cas_out high before any image was loaded");

endmodule

bind cas_player cas_player_sva cas_player_sva_inst (
   .clk21m  (clk21m),
   .rst_n   (rst_n),
   .mem_req (mem_req),
   .mem_rsp (mem_rsp),
   .loaded  (tape_fetch_inst.loaded),
   .cas_out (cas_out)
);

`default_nettype wire

/* test/tape_mem_model.sv */
// Testbench image memory: answers one read at a time after a random delay of 1 to max_latency
`default_nettype none

module tape_mem_model (
   input  logic              clk21m,
   input  logic              rst_n,
   input  int unsigned       max_latency,
   input  cas_pkg::mem_req_t mem_req,
   output cas_pkg::mem_rsp_t mem_rsp
);
   import cas_pkg::*;

   // Written directly by the testbench before each download
   tape_byte_t  image [256];
   logic        busy;
   int unsigned wait_cnt;

   always_ff @(posedge clk21m or negedge rst_n) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         wait_cnt <= 0;
         mem_rsp  <= '0;
      end else begin
         mem_rsp.ready <= 1'b0;
         if (mem_rsp.ready) begin
            // Fetcher drops rd on this edge
            busy <= 1'b0;
         end else if (busy) begin
            if (wait_cnt == 0) begin
               mem_rsp.ready <= 1'b1;
               mem_rsp.data  <= image[mem_req.addr[7:0]];
            end else begin
               wait_cnt <= wait_cnt - 1;
            end
         end else if (mem_req.rd) begin
            busy     <= 1'b1;
            wait_cnt <= $urandom_range(max_latency - 1, 0);
         end
      end
   end

endmodule

`default_nettype wire

/* hw/cas_player.sv */
// Cassette image player top: fetcher, byte FIFO and FSK modulator wired together
`default_nettype none

module cas_player #(
   parameter int unsigned half_period = cas_pkg::HALF_PERIOD_DEFAULT
) (
   input  logic                clk21m,
   input  logic                rst_n,
   input  logic                cas_download,
   input  logic                rewind_req,
   input  logic                motor_n,
   input  cas_pkg::tape_addr_t tape_len,
   input  cas_pkg::mem_rsp_t   mem_rsp,
   output cas_pkg::mem_req_t   mem_req,
   output logic                cas_out
);
   import cas_pkg::*;

   logic [FIFO_CNT_W-1:0] fifo_count;
   logic                  push;
   tape_byte_t            push_data;
   logic                  flush;
   logic                  play;
   logic                  pop;
   logic                  empty;
   tape_byte_t            head;

   // ============================================================
   // Producer
   // ============================================================

   tape_fetch tape_fetch_inst (
      .clk21m       (clk21m),
      .rst_n        (rst_n),
      .cas_download (cas_download),
      .rewind_req   (rewind_req),
      .motor_n      (motor_n),
      .tape_len     (tape_len),
      .mem_rsp      (mem_rsp),
      .fifo_count   (fifo_count),
      .mem_req      (mem_req),
      .push         (push),
      .push_data    (push_data),
      .flush        (flush),
      .play         (play)
   );

   // Buffer
   byte_fifo byte_fifo_inst (
      .clk21m    (clk21m),
      .rst_n     (rst_n),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .flush     (flush),
      .head      (head),
      .empty     (empty),
      .count     (fifo_count)
   );

   // Consumer
   fsk_modulator #(
      .half_period (half_period)
   ) fsk_modulator_inst (
      .clk21m  (clk21m),
      .rst_n   (rst_n),
      .play    (play),
      .flush   (flush),
      .empty   (empty),
      .head    (head),
      .pop     (pop),
      .cas_out (cas_out)
   );

endmodule

`default_nettype wire

/* hw/fsk_modulator.sv */
// FSK modulator: frames each buffered byte and drives the 1200 baud tape level
`default_nettype none

module fsk_modulator #(
   parameter int unsigned half_period = cas_pkg::HALF_PERIOD_DEFAULT
) (
   input  logic                clk21m,
   input  logic                rst_n,
   input  logic                play,
   input  logic                flush,
   input  logic                empty,
   input  cas_pkg::tape_byte_t head,
   output logic                pop,
   output logic                cas_out
);
   import cas_pkg::*;

   fsk_state_t             state;
   logic [FRAME_BITS-1:0]  frame;
   logic [HALF_CNT_W-1:0]  hp_cnt;
   logic [1:0]             hc_cnt;
   logic [BIT_CNT_W-1:0]   bit_cnt;
   logic                   hp_end;
   logic                   bit_end;
   logic                   frame_end;
   logic                   start_frame;

   // ============================================================
   // Bit and frame boundaries
   // ============================================================

   // A bit is four half-periods of the 2400 Hz tone
   assign hp_end    = (hp_cnt == HALF_CNT_W'(half_period - 1));
   assign bit_end   = hp_end && (hc_cnt == 2'd3);
   assign frame_end = (state == FSK_BIT) && bit_end &&
                      (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

   // Next frame follows back to back when a byte waits
   assign start_frame = play && !empty && !flush &&
                        ((state == FSK_IDLE) || frame_end);
   assign pop = start_frame;

   // Frame shifter, LSB goes out first
   always_ff @(posedge clk21m) begin
      if (start_frame) begin
         frame <= {2'b11, head, 1'b0};
      end else if ((state == FSK_BIT) && bit_end) begin
         frame <= {1'b1, frame[FRAME_BITS-1:1]};
      end
   end

   // ============================================================
   // Tone generation
   // ============================================================

   always_ff @(posedge clk21m or negedge rst_n) begin
      if (!rst_n) begin
         state   <= FSK_IDLE;
         cas_out <= 1'b0;
         hp_cnt  <= '0;
         hc_cnt  <= '0;
         bit_cnt <= '0;
      end else if (flush) begin
         // Rewind aborts the frame mid-bit
         state   <= FSK_IDLE;
         cas_out <= 1'b0;
         hp_cnt  <= '0;
         hc_cnt  <= '0;
         bit_cnt <= '0;
      end else if (start_frame) begin
         state   <= FSK_BIT;
         cas_out <= ~cas_out;
         hp_cnt  <= '0;
         hc_cnt  <= '0;
         bit_cnt <= '0;
      end else if (state == FSK_BIT) begin
         if (frame_end) begin
            // Nothing to send, level holds
            state <= FSK_IDLE;
         end else if (hp_end) begin
            hp_cnt <= '0;
            hc_cnt <= hc_cnt + 1'b1;
            if (bit_end) begin
               bit_cnt <= bit_cnt + 1'b1;
               cas_out <= ~cas_out;
            end else if (frame[0] || (hc_cnt == 2'd1)) begin
               // 1 toggles every half-period, 0 only at mid-bit
               cas_out <= ~cas_out;
            end
         end else begin
            hp_cnt <= hp_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/byte_fifo.sv */
// Small circular byte buffer between the memory fetcher and the FSK modulator
`default_nettype none

module byte_fifo (
   input  logic                           clk21m,
   input  logic                           rst_n,
   input  logic                           push,
   input  cas_pkg::tape_byte_t            push_data,
   input  logic                           pop,
   input  logic                           flush,
   output cas_pkg::tape_byte_t            head,
   output logic                           empty,
   output logic [cas_pkg::FIFO_CNT_W-1:0] count
);
   import cas_pkg::*;

   tape_byte_t            mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic                  do_push;
   logic                  do_pop;

   assign do_push = push && (count < FIFO_CNT_W'(FIFO_DEPTH));
   assign do_pop  = pop && !empty;

   assign head  = mem[rd_ptr];
   assign empty = (count == '0);

   // Storage
   always_ff @(posedge clk21m) begin
      if (do_push && !flush) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // ============================================================
   // Pointers and occupancy
   // ============================================================

   always_ff @(posedge clk21m or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Depth is a power of two, pointers wrap by themselves
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/tape_fetch.sv */
// Tape byte fetcher: tracks the load state and reads image bytes into the byte FIFO
`default_nettype none

module tape_fetch (
   input  logic                           clk21m,
   input  logic                           rst_n,
   input  logic                           cas_download,
   input  logic                           rewind_req,
   input  logic                           motor_n,
   input  cas_pkg::tape_addr_t            tape_len,
   input  cas_pkg::mem_rsp_t              mem_rsp,
   input  logic [cas_pkg::FIFO_CNT_W-1:0] fifo_count,
   output cas_pkg::mem_req_t              mem_req,
   output logic                           push,
   output cas_pkg::tape_byte_t            push_data,
   output logic                           flush,
   output logic                           play
);
   import cas_pkg::*;

   logic         download_q;
   logic         loaded;
   logic         rewind;
   logic         discard;
   logic         can_issue;
   tape_addr_t   addr;
   fetch_state_t state;

   // ============================================================
   // Load latch and rewind
   // ============================================================

   // Image is ready once the download strobe falls
   always_ff @(posedge clk21m or negedge rst_n) begin
      if (!rst_n) begin
         download_q <= 1'b0;
         loaded     <= 1'b0;
      end else begin
         download_q <= cas_download;
         if (download_q && !cas_download) begin
            loaded <= 1'b1;
         end
      end
   end

   assign rewind = cas_download | rewind_req;
   assign flush  = rewind;
   assign play   = loaded & ~motor_n;

   // ============================================================
   // Read FSM
   // ============================================================

   // Only one read in flight, so room checked here cannot vanish
   assign can_issue = play && !rewind && (addr < tape_len) &&
                      (fifo_count < FIFO_CNT_W'(FIFO_DEPTH));

   // Byte is taken straight off the bus in its ready cycle
   assign push      = (state == FETCH_WAIT) && mem_rsp.ready && !discard && !rewind;
   assign push_data = mem_rsp.data;

   always_ff @(posedge clk21m or negedge rst_n) begin
      if (!rst_n) begin
         state   <= FETCH_IDLE;
         mem_req <= '0;
         addr    <= '0;
         discard <= 1'b0;
      end else begin
         if (rewind) begin
            addr <= '0;
         end else if (push) begin
            addr <= addr + 1'b1;
         end

         case (state)
            FETCH_IDLE: begin
               if (can_issue) begin
                  mem_req.rd   <= 1'b1;
                  mem_req.addr <= addr;
                  state        <= FETCH_WAIT;
               end
            end
            FETCH_WAIT: begin
               // Request held until ready; a rewind marks the answer stale
               if (mem_rsp.ready) begin
                  mem_req.rd <= 1'b0;
                  discard    <= 1'b0;
                  state      <= FETCH_IDLE;
               end else if (rewind) begin
                  discard <= 1'b1;
               end
            end
            default: begin
               state <= FETCH_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/cas_pkg.sv */
// Shared constants, bus structs and state types for the cassette image player
`default_nettype none

package cas_pkg;

   // ============================================================
   // Timing and sizing
   // ============================================================

   localparam int TAPE_ADDR_W = 24;

   // One 2400 Hz half-cycle at 21.477 MHz
   localparam int HALF_PERIOD_DEFAULT = 4474;
   localparam int HALF_CNT_W = 16;

   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

   // Start bit, eight data bits, two stop bits
   localparam int FRAME_BITS = 11;
   localparam int BIT_CNT_W = $clog2(FRAME_BITS);

   // ============================================================
   // Types
   // ============================================================

   typedef logic [TAPE_ADDR_W-1:0] tape_addr_t;
   typedef logic [7:0] tape_byte_t;

   // Read request towards image memory
   typedef struct packed {
      logic       rd;
      tape_addr_t addr;
   } mem_req_t;

   // Memory answer, data valid with ready only
   typedef struct packed {
      logic       ready;
      tape_byte_t data;
   } mem_rsp_t;

   typedef enum logic {FETCH_IDLE, FETCH_WAIT} fetch_state_t;
   typedef enum logic {FSK_IDLE, FSK_BIT} fsk_state_t;

endpackage

`default_nettype wire
